// ==== src.f ====
design/dm_mem_pkg.sv
design/hart_event_if.sv
design/hart_bus_decode.sv
design/cmd_ctrl.sv
design/abstract_cmd_gen.sv
design/rdata_mux.sv
design/dm_mem_top.sv
dv/tb_dm_mem.sv

// ==== Makefile ====
# Verilator build and run for the debug memory testbench

TOP = tb_dm_mem

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f src.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/tb_dm_mem.sv ====
/*
 * debug memory testbench
 * drives commands and hart bus traffic, checks against a reference model
 */
`timescale 1ns/100ps

module tb_dm_mem
    import dm_mem_pkg::*;
();

    localparam int TEST_CYCLES = 500;
    localparam time TIMEOUT    = 4 * TEST_CYCLES * 10ns;

    logic                          clk_i = 1'b0;
    logic                          rst_ni;
    logic                          cmd_valid_i;
    logic                          cmd_ready_o;
    cmd_type_e                     cmdtype_i;
    ac_ar_t                        control_i;
    logic [1:0]                    haltreq_i, resumereq_i;
    logic [19:0]                   hartsel_i;
    logic [PROGBUF_SIZE-1:0][31:0] progbuf_i;
    logic [DATA_COUNT-1:0][31:0]   data_i, data_o;
    logic [1:0]                    halted_o, resuming_o;
    logic                          data_valid_o, cmderror_valid_o, cmdbusy_o;
    cmd_err_e                      cmderror_o;
    logic                          req_i, we_i;
    dbg_addr_t                     addr_i;
    dm_word_t                      wdata_i, rdata_o;
    logic [7:0]                    be_i;

    int          errors = 0;
    int          checks = 0;
    logic [31:0] lfsr = 32'hd090;

    dm_mem_top #(.NR_HARTS(2)) UUT (.*);

    always #5 clk_i = ~clk_i;

    // ----------------------------------------
    // helpers and reference model
    // ----------------------------------------
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            // taps 32, 22, 2, 1
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[62:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [2:0] size, input logic [4:0] src);
        // store to 0x380 off a0
        return {7'h1C, src, 5'd10, size, 5'h00, 7'h23};
    endfunction

    function automatic logic [31:0] jal_to(input logic [11:0] target);
        logic [20:0] imm;
        imm = {9'h0, target - 12'h300};
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, 7'h6F};
    endfunction

    function automatic logic [4:0][63:0] ref_abs_words(input ac_ar_t c);
        logic [4:0][63:0] w;
        w[0] = {32'h0000_0517, 32'h0};
        w[1] = {i_type(12'd12, 5'd10, 3'b001, 5'd10, 7'h13),
                i_type(12'd12, 5'd10, 3'b101, 5'd10, 7'h13)};
        w[2] = {2{32'h13}};
        w[3] = {2{32'h13}};
        w[4] = {32'h0010_0073, i_type(12'h7B3, 5'd0, 3'b010, 5'd10, 7'h73)};
        if (c.transfer && c.aarsize < 3'd4) begin
            if (c.regno[15:14] == 2'b00) begin
                w[0][31:0] = i_type(12'h7B3, 5'd10, 3'b001, 5'd0, 7'h73);
            end
            if (c.regno[12]) begin
                w[2][31:0] = c.write ? i_type(12'h380, 5'd10, c.aarsize, c.regno[4:0], 7'h03)
                                     : s_type(c.aarsize, c.regno[4:0]);
            end else begin
                w[2][31:0]  = i_type(12'h7B2, 5'd8, 3'b001, 5'd0, 7'h73);
                w[3][63:32] = i_type(12'h7B2, 5'd0, 3'b010, 5'd8, 7'h73);
                if (c.write) begin
                    w[2][63:32] = i_type(12'h380, 5'd10, c.aarsize, 5'd8, 7'h03);
                    w[3][31:0]  = i_type(c.regno[11:0], 5'd8, 3'b001, 5'd0, 7'h73);
                end else begin
                    w[2][63:32] = i_type(c.regno[11:0], 5'd0, 3'b010, 5'd8, 7'h73);
                    w[3][31:0]  = s_type(c.aarsize, 5'd8);
                end
            end
        end
        if (c.postexec) begin
            w[4][63:32] = 32'h13;
        end
        return w;
    endfunction

    function automatic logic [63:0] ref_merge(input logic [63:0] d, input logic [63:0] wd,
                                              input logic [7:0] be);
        logic [63:0] r;
        r = d;
        for (int i = 0; i < 8; i++) begin
            if (be[i]) r[i*8 +: 8] = wd[i*8 +: 8];
        end
        return r;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic bus_write(input dbg_addr_t a, input dm_word_t d, input logic [7:0] be);
        @(posedge clk_i);
        req_i   <= 1'b1;
        we_i    <= 1'b1;
        addr_i  <= a;
        wdata_i <= d;
        be_i    <= be;
        @(posedge clk_i);
        req_i <= 1'b0;
        we_i  <= 1'b0;
    endtask

    task automatic bus_read(input dbg_addr_t a, output dm_word_t d);
        @(posedge clk_i);
        req_i  <= 1'b1;
        we_i   <= 1'b0;
        addr_i <= a;
        @(posedge clk_i);
        req_i <= 1'b0;
        @(negedge clk_i);
        d = rdata_o;
    endtask

    task automatic send_cmd(input cmd_type_e t, input ac_ar_t c, input cmd_err_e err);
        @(posedge clk_i);
        cmd_valid_i <= 1'b1;
        cmdtype_i   <= t;
        control_i   <= c;
        @(negedge clk_i);
        check("cmd_ready_o", cmd_ready_o, 1);
        check("cmderror_valid_o", cmderror_valid_o, err != ERR_NONE);
        if (err != ERR_NONE) check("cmderror_o", cmderror_o, err);
        @(posedge clk_i);
        cmd_valid_i <= 1'b0;
        cmdtype_i   <= ACCESS_REG;
        @(negedge clk_i);
        check("cmdbusy_o", cmdbusy_o, err == ERR_NONE);
        check("cmd_ready_o", cmd_ready_o, err != ERR_NONE);
        check("cmderror_valid_o", cmderror_valid_o, 0);
    endtask

    task automatic run_cmd(input ac_ar_t c);
        dm_word_t         rd;
        logic [4:0][63:0] exp;
        exp = ref_abs_words(c);
        send_cmd(ACCESS_REG, c, ERR_NONE);
        bus_read(FLAGS_BASE, rd);
        check("rdata_o flags", rd, 64'h1);
        bus_read(WHERETO_ADDR, rd);
        check("rdata_o whereto", rd, {32'h0, jal_to(c.transfer ? 12'h348 : 12'h370)});
        bus_write(GOING_ADDR, 64'h0, 8'hFF);
        for (int i = 0; i < 5; i++) begin
            bus_read(dbg_addr_t'(ABS_CMD_BASE + 8 * i), rd);
            check($sformatf("rdata_o abs word %0d", i), rd, exp[i]);
        end
        bus_write(HALTED_ADDR, 64'h0, 8'hFF);
        @(negedge clk_i);
        check("cmd_ready_o", cmd_ready_o, 1);
        check("cmdbusy_o", cmdbusy_o, 0);
    endtask

    // data register writes are checked against the merge model
    always @(negedge clk_i) begin
        if (rst_ni) begin
            if (req_i && we_i && addr_i >= DATA_BASE && addr_i <= DATA_END) begin
                check("data_valid_o", data_valid_o, 1);
                check("data_o", data_o, ref_merge(data_i, wdata_i, be_i));
            end else begin
                check("data_valid_o", data_valid_o, 0);
                check("data_o", data_o, data_i);
            end
        end
    end

    initial begin
        #(TIMEOUT);
        $display("watchdog expired before the tests completed");
        $display("Test failures found");
        $finish;
    end

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    initial begin
        ac_ar_t   c;
        dm_word_t rd;
        rst_ni      <= 1'b0;
        cmd_valid_i <= 1'b0;
        cmdtype_i   <= ACCESS_REG;
        control_i   <= '0;
        haltreq_i   <= '0;
        resumereq_i <= '0;
        hartsel_i   <= '0;
        progbuf_i   <= {32'h4444_0004, 32'h3333_0003, 32'h2222_0002, 32'h1111_0001};
        data_i      <= {32'hD1D1_0001, 32'hD0D0_0000};
        req_i       <= 1'b0;
        we_i        <= 1'b0;
        addr_i      <= '0;
        wdata_i     <= '0;
        be_i        <= '0;
        repeat (2) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        check("cmd_ready_o", cmd_ready_o, 1);
        check("halted_o", halted_o, 0);
        check("resuming_o", resuming_o, 0);
        check("cmdbusy_o", cmdbusy_o, 0);
        check("cmderror_valid_o", cmderror_valid_o, 0);
        check("rdata_o", rdata_o, 0);

        c = '0;
        c.transfer = 1'b1;
        c.aarsize  = 3'd2;
        c.regno    = 16'h1005;
        send_cmd(ACCESS_REG, c, ERR_HALT_RESUME);
        bus_write(HALTED_ADDR, 64'h0, 8'hFF);
        @(negedge clk_i);
        check("halted_o", halted_o, 2'b01);
        send_cmd(ACCESS_MEM, c, ERR_NOT_SUPPORTED);

        run_cmd(c);
        c.transfer = 1'b0;
        run_cmd(c);
        c          = '0;
        c.transfer = 1'b1;
        c.aarsize  = 3'd3;
        c.regno    = 16'hC300;
        run_cmd(c);
        for (int n = 0; n < 12; n++) begin
            c          = '0;
            c.transfer = 1'b1;
            c.aarsize  = rand_bits(1) ? 3'd3 : 3'd2;
            c.write    = rand_bits(1);
            c.postexec = rand_bits(1);
            c.regno    = rand_bits(1) ? {11'h080, 5'(rand_bits(5))} : {4'h0, 12'(rand_bits(12))};
            run_cmd(c);
        end

        // exception from the hart
        @(posedge clk_i);
        req_i  <= 1'b1;
        we_i   <= 1'b1;
        addr_i <= EXCEPTION_ADDR;
        @(negedge clk_i);
        check("cmderror_valid_o", cmderror_valid_o, 1);
        check("cmderror_o", cmderror_o, ERR_EXCEPTION);
        @(posedge clk_i);
        req_i <= 1'b0;
        we_i  <= 1'b0;

        for (int n = 0; n < 20; n++) begin
            @(posedge clk_i);
            data_i <= rand_bits(64);
            bus_write(rand_bits(1) ? 12'h384 : 12'h380, rand_bits(64), 8'(rand_bits(8)));
        end
        bus_read(DATA_BASE, rd);
        check("rdata_o data", rd, data_i);
        bus_read(PROGBUF_BASE, rd);
        check("rdata_o progbuf 0", rd, {progbuf_i[1], progbuf_i[0]});
        bus_read(12'h378, rd);
        check("rdata_o progbuf 1", rd, {progbuf_i[3], progbuf_i[2]});

        // resume of hart 0
        @(posedge clk_i);
        resumereq_i <= 2'b01;
        bus_read(FLAGS_BASE, rd);
        check("rdata_o flags", rd, 64'h2);
        bus_read(WHERETO_ADDR, rd);
        check("rdata_o whereto", rd, {32'h0, jal_to(12'h808)});
        bus_write(RESUMING_ADDR, 64'h0, 8'hFF);
        @(negedge clk_i);
        check("halted_o", halted_o, 0);
        check("resuming_o", resuming_o, 2'b01);
        @(posedge clk_i);
        resumereq_i <= 2'b00;
        @(posedge clk_i);
        @(negedge clk_i);
        check("resuming_o", resuming_o, 0);

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== design/dm_mem_top.sv ====
/*
 * debug module memory top level
 * hart bus decode, command control, code generation and read path
 */
`timescale 1ns/100ps

module dm_mem_top
    import dm_mem_pkg::*;
#(
    parameter int NR_HARTS = 2
) (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    // debugger side
    input  logic                          cmd_valid_i,
    output logic                          cmd_ready_o,
    input  cmd_type_e                     cmdtype_i,
    input  ac_ar_t                        control_i,
    input  logic [NR_HARTS-1:0]           haltreq_i,
    input  logic [NR_HARTS-1:0]           resumereq_i,
    input  logic [19:0]                   hartsel_i,
    input  logic [PROGBUF_SIZE-1:0][31:0] progbuf_i,
    input  logic [DATA_COUNT-1:0][31:0]   data_i,
    output logic [NR_HARTS-1:0]           halted_o,
    output logic [NR_HARTS-1:0]           resuming_o,
    output logic [DATA_COUNT-1:0][31:0]   data_o,
    output logic                          data_valid_o,
    output logic                          cmderror_valid_o,
    output cmd_err_e                      cmderror_o,
    output logic                          cmdbusy_o,
    // hart bus
    input  logic                          req_i,
    input  logic                          we_i,
    input  dbg_addr_t                     addr_i,
    input  dm_word_t                      wdata_i,
    input  logic [7:0]                    be_i,
    output dm_word_t                      rdata_o
);

    ac_ar_t         cmd_ctrl;
    dm_word_t [4:0] abs_words;
    logic           unsupported;
    logic           go;
    logic           resume;

    hart_event_if #(.NR_HARTS(NR_HARTS)) ev_if ();

    hart_bus_decode #(.NR_HARTS(NR_HARTS)) u_decode (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .req_i        (req_i),
        .we_i         (we_i),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .be_i         (be_i),
        .data_i       (data_i),
        .data_o       (data_o),
        .data_valid_o (data_valid_o),
        .ev           (ev_if)
    );

    cmd_ctrl #(.NR_HARTS(NR_HARTS)) u_ctrl (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .cmd_valid_i      (cmd_valid_i),
        .cmd_ready_o      (cmd_ready_o),
        .cmdtype_i        (cmdtype_i),
        .control_i        (control_i),
        .haltreq_i        (haltreq_i),
        .resumereq_i      (resumereq_i),
        .hartsel_i        (hartsel_i),
        .ev               (ev_if),
        .unsupported_i    (unsupported),
        .cmd_ctrl_o       (cmd_ctrl),
        .halted_o         (halted_o),
        .resuming_o       (resuming_o),
        .go_o             (go),
        .resume_o         (resume),
        .cmdbusy_o        (cmdbusy_o),
        .cmderror_valid_o (cmderror_valid_o),
        .cmderror_o       (cmderror_o)
    );

    abstract_cmd_gen u_gen (
        .cmdtype_i     (cmdtype_i),
        .ac_ar_i       (cmd_ctrl),
        .words_o       (abs_words),
        .unsupported_o (unsupported)
    );

    rdata_mux #(.NR_HARTS(NR_HARTS)) u_rdata (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .req_i       (req_i),
        .we_i        (we_i),
        .addr_i      (addr_i),
        .hartsel_i   (hartsel_i),
        .resumereq_i (resumereq_i),
        .cmdbusy_i   (cmdbusy_o),
        .transfer_i  (cmd_ctrl.transfer),
        .go_i        (go),
        .resume_i    (resume),
        .progbuf_i   (progbuf_i),
        .data_i      (data_i),
        .abs_words_i (abs_words),
        .rdata_o     (rdata_o)
    );

endmodule

// ==== design/rdata_mux.sv ====
/*
 * hart bus read path
 * registers WhereTo, data, program buffer, abstract command and flag reads
 */
`timescale 1ns/100ps

module rdata_mux
    import dm_mem_pkg::*;
#(
    parameter int NR_HARTS = 2
) (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          req_i,
    input  logic                          we_i,
    input  dbg_addr_t                     addr_i,
    input  logic [19:0]                   hartsel_i,
    input  logic [NR_HARTS-1:0]           resumereq_i,
    input  logic                          cmdbusy_i,
    input  logic                          transfer_i,
    input  logic                          go_i,
    input  logic                          resume_i,
    input  logic [PROGBUF_SIZE-1:0][31:0] progbuf_i,
    input  logic [DATA_COUNT-1:0][31:0]   data_i,
    input  dm_word_t [4:0]                abs_words_i,
    output dm_word_t                      rdata_o
);

    localparam int HARTSEL_W = (NR_HARTS > 1) ? $clog2(NR_HARTS) : 1;
    localparam int PB_IDX_W  = (PROGBUF_SIZE > 2) ? $clog2(PROGBUF_SIZE / 2) : 1;

    logic [HARTSEL_W-1:0]              hart_sel;
    logic [PROGBUF_SIZE/2-1:0][63:0]   progbuf_dw;
    logic [8:0]                        pb_off;
    logic [8:0]                        abs_off;
    logic [8:0]                        flag_off;
    logic [7:0][7:0]                   flag_bytes;
    dm_word_t                          rdata_d, rdata_q;

    assign hart_sel   = hartsel_i[HARTSEL_W-1:0];
    assign progbuf_dw = progbuf_i;
    // double word offsets into each region
    assign pb_off     = addr_i[11:3] - PROGBUF_BASE[11:3];
    assign abs_off    = addr_i[11:3] - ABS_CMD_BASE[11:3];
    assign flag_off   = addr_i[11:3] - FLAGS_BASE[11:3];
    assign rdata_o    = rdata_q;

    always_comb begin
        rdata_d    = rdata_q;
        flag_bytes = '0;
        if (req_i && !we_i) begin
            rdata_d = '0;
            if (addr_i == WHERETO_ADDR) begin
                rdata_d = rdata_q;
                if (cmdbusy_i && transfer_i) begin
                    rdata_d = {32'h0, enc_jal(5'd0, {9'h0, ABS_CMD_BASE - WHERETO_ADDR})};
                end else if (cmdbusy_i) begin
                    // no transfer, straight into the program buffer
                    rdata_d = {32'h0, enc_jal(5'd0, {9'h0, PROGBUF_BASE - WHERETO_ADDR})};
                end else if (resumereq_i[hart_sel]) begin
                    rdata_d = {32'h0, enc_jal(5'd0, {9'h0, RESUME_ADDR - WHERETO_ADDR})};
                end
            end else if ((addr_i >= DATA_BASE) && (addr_i <= DATA_END)) begin
                rdata_d = data_i;
            end else if ((addr_i >= PROGBUF_BASE) && (addr_i <= PROGBUF_END)) begin
                rdata_d = progbuf_dw[pb_off[PB_IDX_W-1:0]];
            end else if ((addr_i >= ABS_CMD_BASE) && (addr_i <= ABS_CMD_END)) begin
                rdata_d = abs_words_i[abs_off[2:0]];
            end else if ((addr_i >= FLAGS_BASE) && (addr_i <= FLAGS_END)) begin
                // one byte per hart, only the selected hart is released
                if (flag_off == hartsel_i[11:3]) begin
                    flag_bytes[hartsel_i[2:0]] = {6'b0, resume_i, go_i};
                end
                rdata_d = flag_bytes;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rdata_q <= '0;
        end else begin
            rdata_q <= rdata_d;
        end
    end

endmodule

// ==== design/abstract_cmd_gen.sv ====
/*
 * abstract command generator
 * five double words of code for the access register command
 */
`timescale 1ns/100ps

module abstract_cmd_gen
    import dm_mem_pkg::*;
(
    input  cmd_type_e      cmdtype_i,
    input  ac_ar_t         ac_ar_i,
    output dm_word_t [4:0] words_o,
    output logic           unsupported_o
);

    localparam logic [4:0] REG_S0   = 5'd8;
    localparam logic [4:0] REG_A0   = 5'd10;

    always_comb begin
        unsupported_o = 1'b0;

        // base program leaves the debug module base in a0
        words_o[0][31:0]  = enc_illegal();
        words_o[0][63:32] = enc_auipc(REG_A0, 32'h0);
        words_o[1][31:0]  = enc_srli(REG_A0, REG_A0, 6'd12);
        words_o[1][63:32] = enc_slli(REG_A0, REG_A0, 6'd12);
        words_o[2]        = {enc_nop(), enc_nop()};
        words_o[3]        = {enc_nop(), enc_nop()};
        words_o[4][31:0]  = enc_csrr(DSCRATCH1, REG_A0);
        words_o[4][63:32] = enc_ebreak();

        if (cmdtype_i != ACCESS_REG) begin
            unsupported_o = 1'b1;
        end else begin
            if (ac_ar_i.transfer && (ac_ar_i.aarsize < 3'd4)) begin
                // save a0 unless regno falls in the reserved range
                if (ac_ar_i.regno[15:14] != 2'b00) begin
                    words_o[0][31:0] = enc_illegal();
                end else begin
                    words_o[0][31:0] = enc_csrw(DSCRATCH1, REG_A0);
                end

                if (ac_ar_i.regno[12]) begin
                    // GPR transfer is a single access to the data registers
                    if (ac_ar_i.write) begin
                        words_o[2][31:0] = enc_load(ac_ar_i.aarsize, ac_ar_i.regno[4:0],
                                                    REG_A0, DATA_BASE);
                    end else begin
                        words_o[2][31:0] = enc_store(ac_ar_i.aarsize, ac_ar_i.regno[4:0],
                                                     REG_A0, DATA_BASE);
                    end
                end else if (ac_ar_i.write) begin
                    // CSR write goes through s0
                    words_o[2][31:0]  = enc_csrw(DSCRATCH0, REG_S0);
                    words_o[2][63:32] = enc_load(ac_ar_i.aarsize, REG_S0, REG_A0, DATA_BASE);
                    words_o[3][31:0]  = enc_csrw(ac_ar_i.regno[11:0], REG_S0);
                    words_o[3][63:32] = enc_csrr(DSCRATCH0, REG_S0);
                end else begin
                    words_o[2][31:0]  = enc_csrw(DSCRATCH0, REG_S0);
                    words_o[2][63:32] = enc_csrr(ac_ar_i.regno[11:0], REG_S0);
                    words_o[3][31:0]  = enc_store(ac_ar_i.aarsize, REG_S0, REG_A0, DATA_BASE);
                    words_o[3][63:32] = enc_csrr(DSCRATCH0, REG_S0);
                end
            end

            // fall through into the program buffer
            if (ac_ar_i.postexec) begin
                words_o[4][63:32] = enc_nop();
            end
        end
    end

endmodule

// ==== design/cmd_ctrl.sv ====
/*
 * abstract command controller
 * command FSM, per-hart halted and resuming flags, error reporting
 */
`timescale 1ns/100ps

module cmd_ctrl
    import dm_mem_pkg::*;
#(
    parameter int NR_HARTS = 2
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                cmd_valid_i,
    output logic                cmd_ready_o,
    input  cmd_type_e           cmdtype_i,
    input  ac_ar_t              control_i,
    input  logic [NR_HARTS-1:0] haltreq_i,
    input  logic [NR_HARTS-1:0] resumereq_i,
    input  logic [19:0]         hartsel_i,
    hart_event_if.ctrl          ev,
    input  logic                unsupported_i,
    output ac_ar_t              cmd_ctrl_o,
    output logic [NR_HARTS-1:0] halted_o,
    output logic [NR_HARTS-1:0] resuming_o,
    output logic                go_o,
    output logic                resume_o,
    output logic                cmdbusy_o,
    output logic                cmderror_valid_o,
    output cmd_err_e            cmderror_o
);

    localparam int HARTSEL_W = (NR_HARTS > 1) ? $clog2(NR_HARTS) : 1;

    typedef enum logic [1:0] {IDLE, GO, RESUME, CMD_EXEC} state_e;

    state_e               state_d, state_q;
    logic [NR_HARTS-1:0]  halted_d, halted_q;
    logic [NR_HARTS-1:0]  resuming_d, resuming_q;
    logic [HARTSEL_W-1:0] hart_sel;
    ac_ar_t               ctrl_q;

    assign hart_sel    = hartsel_i[HARTSEL_W-1:0];
    assign cmd_ready_o = (state_q == IDLE);
    assign cmdbusy_o   = (state_q == GO) || (state_q == CMD_EXEC);
    assign go_o        = (state_q == GO);
    assign resume_o    = (state_q == RESUME);
    assign halted_o    = halted_q;
    assign resuming_o  = resuming_q;
    assign cmd_ctrl_o  = ctrl_q;

    // ----------------------------------------
    // command FSM and errors
    // ----------------------------------------
    always_comb begin
        state_d          = state_q;
        cmderror_valid_o = 1'b0;
        cmderror_o       = ERR_NONE;
        case (state_q)
            IDLE: begin
                if (cmd_valid_i) begin
                    cmderror_valid_o = unsupported_i || !halted_q[hart_sel];
                    if (unsupported_i) begin
                        cmderror_o = ERR_NOT_SUPPORTED;
                    end else if (!halted_q[hart_sel]) begin
                        cmderror_o = ERR_HALT_RESUME;
                    end else begin
                        state_d = GO;
                    end
                end else if (resumereq_i[hart_sel] && !haltreq_i[hart_sel] &&
                             halted_q[hart_sel] && !resuming_q[hart_sel]) begin
                    state_d = RESUME;
                end
            end
            GO: begin
                if (ev.going_wr) begin
                    state_d = CMD_EXEC;
                end
            end
            CMD_EXEC: begin
                // hart parks itself again once the program is done
                if (ev.halted_wr) begin
                    state_d = IDLE;
                end
            end
            RESUME: begin
                if (ev.resuming_wr) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase

        if (ev.exception_wr) begin
            cmderror_valid_o = 1'b1;
            cmderror_o       = ERR_EXCEPTION;
        end
    end

    // ----------------------------------------
    // hart flags
    // ----------------------------------------
    always_comb begin
        halted_d   = halted_q;
        // resuming acknowledge drops with the request
        resuming_d = resuming_q & resumereq_i;
        if (ev.halted_wr) begin
            halted_d[ev.hart_idx] = 1'b1;
        end
        if (ev.resuming_wr) begin
            halted_d[ev.hart_idx]   = 1'b0;
            resuming_d[ev.hart_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= IDLE;
            halted_q   <= '0;
            resuming_q <= '0;
        end else begin
            state_q    <= state_d;
            halted_q   <= halted_d;
            resuming_q <= resuming_d;
        end
    end

    // only an access register command carries a meaningful control word
    always_ff @(posedge clk_i) begin
        if (cmd_valid_i && cmd_ready_o) begin
            ctrl_q <= (cmdtype_i == ACCESS_REG) ? control_i : '0;
        end
    end

endmodule

// ==== design/hart_bus_decode.sv ====
/*
 * hart bus write decoder
 * turns flag writes into events and merges data register writes
 */
`timescale 1ns/100ps

module hart_bus_decode
    import dm_mem_pkg::*;
#(
    parameter int NR_HARTS = 2
) (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        req_i,
    input  logic                        we_i,
    input  dbg_addr_t                   addr_i,
    input  dm_word_t                    wdata_i,
    input  logic [7:0]                  be_i,
    input  logic [DATA_COUNT-1:0][31:0] data_i,
    output logic [DATA_COUNT-1:0][31:0] data_o,
    output logic                        data_valid_o,
    hart_event_if.decoder               ev
);

    localparam int HARTSEL_W = (NR_HARTS > 1) ? $clog2(NR_HARTS) : 1;

    logic                 wr;
    logic                 flag_wr;
    logic [HARTSEL_W-1:0] idx_q;

    assign wr      = req_i && we_i;
    // 0x100 to 0x10F holds the four flag words
    assign flag_wr = wr && (addr_i[11:4] == HALTED_ADDR[11:4]);

    assign ev.halted_wr    = wr && (addr_i == HALTED_ADDR);
    assign ev.going_wr     = wr && (addr_i == GOING_ADDR);
    assign ev.resuming_wr  = wr && (addr_i == RESUMING_ADDR);
    assign ev.exception_wr = wr && (addr_i == EXCEPTION_ADDR);

    // the hart puts its own index in the write data,
    // keep the last one so the index stays stable between writes
    assign ev.hart_idx = flag_wr ? wdata_i[HARTSEL_W-1:0] : idx_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            idx_q <= '0;
        end else if (flag_wr) begin
            idx_q <= wdata_i[HARTSEL_W-1:0];
        end
    end

    // ----------------------------------------
    // data register writes
    // ----------------------------------------
    always_comb begin
        data_o       = data_i;
        data_valid_o = 1'b0;
        if (wr && (addr_i >= DATA_BASE) && (addr_i <= DATA_END)) begin
            data_valid_o = 1'b1;
            for (int i = 0; i < 4 * DATA_COUNT; i++) begin
                if (be_i[i]) begin
                    data_o[i / 4][(i % 4) * 8 +: 8] = wdata_i[i * 8 +: 8];
                end
            end
        end
    end

endmodule

// ==== design/hart_event_if.sv ====
/*
 * hart event interface
 * single-cycle write events seen on the hart bus
 */
`timescale 1ns/100ps

interface hart_event_if #(
    parameter int NR_HARTS = 2
);
    localparam int HARTSEL_W = (NR_HARTS > 1) ? $clog2(NR_HARTS) : 1;

    logic                 halted_wr;
    logic                 going_wr;
    logic                 resuming_wr;
    logic                 exception_wr;
    logic [HARTSEL_W-1:0] hart_idx;

    modport decoder (
        output halted_wr, going_wr, resuming_wr, exception_wr, hart_idx
    );

    modport ctrl (
        input halted_wr, going_wr, resuming_wr, exception_wr, hart_idx
    );

endinterface

// ==== design/dm_mem_pkg.sv ====
/*
 * debug memory package
 * address map, abstract command types and RISC-V instruction encoders
 */
package dm_mem_pkg;

    typedef logic [11:0] dbg_addr_t;
    typedef logic [63:0] dm_word_t;

    // ----------------------------------------
    // address map
    // ----------------------------------------
    localparam dbg_addr_t HALTED_ADDR    = 12'h100;
    localparam dbg_addr_t GOING_ADDR     = 12'h104;
    localparam dbg_addr_t RESUMING_ADDR  = 12'h108;
    localparam dbg_addr_t EXCEPTION_ADDR = 12'h10C;
    localparam dbg_addr_t WHERETO_ADDR   = 12'h300;
    localparam dbg_addr_t ABS_CMD_BASE   = 12'h348;
    localparam dbg_addr_t PROGBUF_BASE   = 12'h370;
    localparam dbg_addr_t DATA_BASE      = 12'h380;
    localparam dbg_addr_t FLAGS_BASE     = 12'h400;
    localparam dbg_addr_t FLAGS_END      = 12'h7FF;
    // jump target only, the ROM behind it lives elsewhere
    localparam dbg_addr_t RESUME_ADDR    = 12'h808;

    // sizes in 32-bit words
    localparam int DATA_COUNT   = 2;
    localparam int PROGBUF_SIZE = 4;

    // inclusive region ends
    localparam dbg_addr_t ABS_CMD_END = dbg_addr_t'(ABS_CMD_BASE + 5 * 8 - 1);
    localparam dbg_addr_t PROGBUF_END = dbg_addr_t'(PROGBUF_BASE + 4 * PROGBUF_SIZE - 1);
    localparam dbg_addr_t DATA_END    = dbg_addr_t'(DATA_BASE + 4 * DATA_COUNT - 1);

    // ----------------------------------------
    // abstract commands
    // ----------------------------------------
    typedef enum logic [7:0] {
        ACCESS_REG   = 8'd0,
        QUICK_ACCESS = 8'd1,
        ACCESS_MEM   = 8'd2
    } cmd_type_e;

    typedef enum logic [2:0] {
        ERR_NONE          = 3'd0,
        ERR_NOT_SUPPORTED = 3'd2,
        ERR_EXCEPTION     = 3'd3,
        ERR_HALT_RESUME   = 3'd4
    } cmd_err_e;

    // access register control word, postincrement kept as reserved
    typedef struct packed {
        logic        zero1;
        logic [2:0]  aarsize;
        logic        zero0;
        logic        postexec;
        logic        transfer;
        logic        write;
        logic [15:0] regno;
    } ac_ar_t;

    localparam logic [11:0] DSCRATCH0 = 12'h7B2;
    localparam logic [11:0] DSCRATCH1 = 12'h7B3;

    // ----------------------------------------
    // instruction encoders
    // ----------------------------------------
    function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6F};
    endfunction

    function automatic logic [31:0] enc_auipc(input logic [4:0] rd, input logic [31:0] imm);
        return {imm[31:12], rd, 7'h17};
    endfunction

    function automatic logic [31:0] enc_srli(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [5:0] shamt);
        return {6'b0, shamt, rs1, 3'b101, rd, 7'h13};
    endfunction

    function automatic logic [31:0] enc_slli(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [5:0] shamt);
        return {6'b0, shamt, rs1, 3'b001, rd, 7'h13};
    endfunction

    function automatic logic [31:0] enc_load(input logic [2:0] size, input logic [4:0] dest,
                                             input logic [4:0] base, input logic [11:0] offset);
        return {offset, base, size, dest, 7'h03};
    endfunction

    function automatic logic [31:0] enc_store(input logic [2:0] size, input logic [4:0] src,
                                              input logic [4:0] base, input logic [11:0] offset);
        return {offset[11:5], src, base, size, offset[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_csrw(input logic [11:0] csr, input logic [4:0] rs1);
        return {csr, rs1, 3'b001, 5'd0, 7'h73};
    endfunction

    function automatic logic [31:0] enc_csrr(input logic [11:0] csr, input logic [4:0] dest);
        return {csr, 5'd0, 3'b010, dest, 7'h73};
    endfunction

    function automatic logic [31:0] enc_nop();
        return 32'h0000_0013;
    endfunction

    function automatic logic [31:0] enc_ebreak();
        return 32'h0010_0073;
    endfunction

    function automatic logic [31:0] enc_illegal();
        return 32'h0000_0000;
    endfunction

endpackage
